// File: cache_addr_pkg.sv
`default_nettype none

`include "cache_defines.svh"

// ------------------------------
// Address field types
// ------------------------------

package cache_addr_pkg;

    // Full byte address as seen on the client side
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // Selects one line of the tag and status memories
    typedef logic [`INDEX_WIDTH-1:0] index_t;

    // Upper address bits stored per line and compared on every access
    typedef logic [`TAG_WIDTH-1:0] tag_t;

    // The byte offset has no type of its own
    // The directory never looks below line granularity

endpackage : cache_addr_pkg

`default_nettype wire

// File: cache_defines.svh
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

// ------------------------------
// Address layout of the directory
// ------------------------------

// Width of the byte address issued by the client
`define ADDR_WIDTH 16

// Byte select inside one line, lowest bits of the address
`define OFFSET_WIDTH 2

// Line select, the bits just above the offset
`define INDEX_WIDTH 4

// Everything above index and offset is kept as the tag
`define TAG_WIDTH (`ADDR_WIDTH - `INDEX_WIDTH - `OFFSET_WIDTH)

// One directory entry per index value, 16 lines in total
`define CACHE_DEPTH (1 << `INDEX_WIDTH)

// The three fields must tile the address exactly
// A change to INDEX_WIDTH resizes both memories and the tag together

`endif

// File: cache_directory_chk.sv
`timescale 1ns/1ps
`default_nettype none

module cache_directory_chk import cache_addr_pkg::*; (
    input wire logic clk_i,
    input wire logic reset_i,
    input wire logic req_i,
    input wire logic ack_i,
    input wire logic hit_i,
    input wire logic dirty_i,
    input wire logic writeback_i,
    input wire tag_t victim_tag_i
);

    // One tally per assertion, the testbench reads the sum
    int latency_fails = 0;
    int release_fails = 0;
    int stable_fails  = 0;
    int reset_fails   = 0;
    int failures;

    assign failures = latency_fails + release_fails + stable_fails + reset_fails;

    // ------------------------------
    // Handshake timing
    // ------------------------------

    // Sampled ack_o turns high four samples after the first sample of a high req_i
    assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(ack_i) |-> $past(req_i, 4) && !$past(req_i, 5))
    else begin
        latency_fails++;
        $error("ack_o rose at a latency other than three cycles after req_i");
    end

    // Once req_i has been sampled low, ack_o drops at the following edge
    assert property (@(posedge clk_i) disable iff (reset_i)
        ack_i && $past(ack_i) && !$past(req_i) |=> !ack_i)
    else begin
        release_fails++;
        $error("ack_o stayed high after req_i was released");
    end

    // Response pins may only change while ack_o is low
    assert property (@(posedge clk_i) disable iff (reset_i)
        ack_i && $past(ack_i) |-> $stable(hit_i) && $stable(dirty_i)
            && $stable(writeback_i) && $stable(victim_tag_i))
    else begin
        stable_fails++;
        $error("response changed while ack_o was high");
    end

    // ------------------------------
    // Reset state
    // ------------------------------

    assert property (@(posedge clk_i)
        $past(reset_i) |-> !ack_i && !hit_i && !dirty_i && !writeback_i && victim_tag_i == '0)
    else begin
        reset_fails++;
        $error("handshake or response not cleared by reset");
    end

endmodule : cache_directory_chk

bind cache_directory_top cache_directory_chk u_chk (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (req_i),
    .ack_i        (ack_o),
    .hit_i        (hit_o),
    .dirty_i      (dirty_o),
    .writeback_i  (writeback_o),
    .victim_tag_i (victim_tag_o)
);

`default_nettype wire

// File: cache_directory_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_directory_top import cache_addr_pkg::*, cache_op_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      reset_i,

    // Client handshake
    input  wire logic      req_i,
    input  wire cache_op_t op_i,
    input  wire addr_t     addr_i,
    output logic           ack_o,
    output logic           hit_o,
    output logic           dirty_o,
    output logic           writeback_o,
    output tag_t           victim_tag_o,

    // Probe port into the status memory
    input  wire logic      probe_en_i,
    input  wire index_t    probe_index_i,
    output logic           probe_valid_o,
    output logic           probe_dirty_o
);

    // ------------------------------
    // Internal nets
    // ------------------------------

    // Controller to tag memory
    logic   tag_rd;
    logic   tag_wr;
    index_t line_index;
    tag_t   wr_tag;
    tag_t   rd_tag;

    // Controller to status memory port 0
    logic   stat_rd;
    logic   stat_wr;
    logic   stat_valid_wr;
    logic   stat_dirty_wr;
    logic   stat_valid_rd;
    logic   stat_dirty_rd;

    // ------------------------------
    // Instances
    // ------------------------------

    tag_memory u_tag (
        .clk_i    (clk_i),
        .rd_en_i  (tag_rd),
        .wr_en_i  (tag_wr),
        .index_i  (line_index),
        .wr_tag_i (wr_tag),
        .rd_tag_o (rd_tag)
    );

    // Port 0 shares the line index with the tag memory
    status_memory u_status (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .port0_index_i (line_index),
        .port0_rd_en_i (stat_rd),
        .port0_wr_en_i (stat_wr),
        .port0_valid_i (stat_valid_wr),
        .port0_dirty_i (stat_dirty_wr),
        .port0_valid_o (stat_valid_rd),
        .port0_dirty_o (stat_dirty_rd),
        .port1_rd_en_i (probe_en_i),
        .port1_index_i (probe_index_i),
        .port1_valid_o (probe_valid_o),
        .port1_dirty_o (probe_dirty_o)
    );

    directory_control u_ctrl (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .req_i        (req_i),
        .op_i         (op_i),
        .addr_i       (addr_i),
        .ack_o        (ack_o),
        .hit_o        (hit_o),
        .dirty_o      (dirty_o),
        .writeback_o  (writeback_o),
        .victim_tag_o (victim_tag_o),
        .tag_rd_o     (tag_rd),
        .tag_wr_o     (tag_wr),
        .index_o      (line_index),
        .wr_tag_o     (wr_tag),
        .rd_tag_i     (rd_tag),
        .stat_rd_o    (stat_rd),
        .stat_wr_o    (stat_wr),
        .stat_valid_o (stat_valid_wr),
        .stat_dirty_o (stat_dirty_wr),
        .stat_valid_i (stat_valid_rd),
        .stat_dirty_i (stat_dirty_rd)
    );

endmodule : cache_directory_top

`default_nettype wire

// File: cache_op_pkg.sv
`default_nettype none

// ------------------------------
// Operation and control types
// ------------------------------

package cache_op_pkg;

    // Operations a client can request, one per handshake
    typedef enum logic [1:0] {
        OP_LOOKUP     = 2'd0,
        OP_FILL       = 2'd1,
        OP_WRITE      = 2'd2,
        OP_INVALIDATE = 2'd3
    } cache_op_t;

    // Handshake controller states
    // READ launches both memory reads, RESOLVE sees their data and writes back
    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_READ    = 2'd1,
        ST_RESOLVE = 2'd2,
        ST_ACK     = 2'd3
    } ctrl_state_t;

endpackage : cache_op_pkg

`default_nettype wire

// File: directory_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module directory_control import cache_addr_pkg::*, cache_op_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      reset_i,

    // Client handshake and response
    input  wire logic      req_i,
    input  wire cache_op_t op_i,
    input  wire addr_t     addr_i,
    output logic           ack_o,
    output logic           hit_o,
    output logic           dirty_o,
    output logic           writeback_o,
    output tag_t           victim_tag_o,

    // Tag memory side
    output logic           tag_rd_o,
    output logic           tag_wr_o,
    output index_t         index_o,
    output tag_t           wr_tag_o,
    input  wire tag_t      rd_tag_i,

    // Status memory port 0 side
    output logic           stat_rd_o,
    output logic           stat_wr_o,
    output logic           stat_valid_o,
    output logic           stat_dirty_o,
    input  wire logic      stat_valid_i,
    input  wire logic      stat_dirty_i
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        req_q;
    index_t      line_index;
    tag_t        addr_tag;
    logic        line_hit;
    logic        resolving;

    // Response computed in the resolve cycle
    logic        hit_d;
    logic        dirty_d;
    logic        writeback_d;
    tag_t        victim_d;

    // Update requested by the current operation
    logic        upd_tag;
    logic        upd_stat;
    logic        new_valid;
    logic        new_dirty;

    // ------------------------------
    // Address split
    // ------------------------------

    // addr_i is held by the client for the whole handshake
    // The offset bits are below line granularity and are ignored
    assign line_index = addr_i[`OFFSET_WIDTH +: `INDEX_WIDTH];
    assign addr_tag   = addr_i[`ADDR_WIDTH-1 -: `TAG_WIDTH];

    assign index_o  = line_index;
    assign wr_tag_o = addr_tag;

    // ------------------------------
    // Handshake FSM
    // ------------------------------

    // req_i is registered once before the FSM sees it
    // This puts ack_o three edges after req_i is first sampled high
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            req_q   <= 1'b0;
            state_q <= ST_IDLE;
        end else begin
            req_q   <= req_i;
            state_q <= state_d;
        end
    end

    // ACK is left only once the client has dropped req
    // A held req keeps the response on the pins indefinitely
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:    if (req_q) state_d = ST_READ;
            ST_READ:    state_d = ST_RESOLVE;
            ST_RESOLVE: state_d = ST_ACK;
            ST_ACK:     if (!req_q) state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
    end

    // Tag and status reads are launched together
    assign tag_rd_o  = (state_q == ST_READ);
    assign stat_rd_o = (state_q == ST_READ);
    assign resolving = (state_q == ST_RESOLVE);
    assign ack_o     = (state_q == ST_ACK);

    // ------------------------------
    // Resolve logic
    // ------------------------------

    // A stale tag of an invalid line never counts as a hit
    assign line_hit = stat_valid_i && (rd_tag_i == addr_tag);

    always_comb begin
        // Defaults cover lookup completely
        hit_d       = line_hit;
        dirty_d     = line_hit && stat_dirty_i;
        writeback_d = 1'b0;
        victim_d    = '0;
        upd_tag     = 1'b0;
        upd_stat    = 1'b0;
        new_valid   = 1'b0;
        new_dirty   = 1'b0;
        case (op_i)
            OP_FILL: begin
                // The old line goes out only if it held modified data
                writeback_d = stat_valid_i && stat_dirty_i;
                // Victim tag is only reported for a line that was in use
                victim_d    = stat_valid_i ? rd_tag_i : '0;
                upd_tag     = 1'b1;
                upd_stat    = 1'b1;
                new_valid   = 1'b1;
            end
            OP_WRITE: begin
                // A miss leaves the directory untouched
                upd_stat  = line_hit;
                new_valid = 1'b1;
                new_dirty = 1'b1;
            end
            OP_INVALIDATE: begin
                writeback_d = line_hit && stat_dirty_i;
                upd_stat    = line_hit;
            end
            default: begin
                // Lookup only reports, nothing is written
                upd_stat = 1'b0;
            end
        endcase
    end

    // Writes land at the edge that enters ACK
    assign tag_wr_o     = resolving && upd_tag;
    assign stat_wr_o    = resolving && upd_stat;
    assign stat_valid_o = new_valid;
    assign stat_dirty_o = new_dirty;

    // Response registers load once per operation and hold until the next one
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hit_o        <= 1'b0;
            dirty_o      <= 1'b0;
            writeback_o  <= 1'b0;
            victim_tag_o <= '0;
        end else if (resolving) begin
            hit_o        <= hit_d;
            dirty_o      <= dirty_d;
            writeback_o  <= writeback_d;
            victim_tag_o <= victim_d;
        end
    end

endmodule : directory_control

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the cache directory testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_cache_directory
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f sim.f --top-module "$TOP" --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# A raised error limit lets the run reach its summary after an assertion fires
"./$BUILD_DIR/V$TOP" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

// File: sim.f
+incdir+.
cache_addr_pkg.sv
cache_op_pkg.sv
tag_memory.sv
status_memory.sv
directory_control.sv
cache_directory_top.sv
cache_directory_chk.sv
tb_cache_directory.sv

// File: status_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module status_memory import cache_addr_pkg::*; (
    input  wire logic   clk_i,
    input  wire logic   reset_i,

    // Port 0, read and write at one index, used by the controller
    input  wire index_t port0_index_i,
    input  wire logic   port0_rd_en_i,
    input  wire logic   port0_wr_en_i,
    input  wire logic   port0_valid_i,
    input  wire logic   port0_dirty_i,
    output logic        port0_valid_o,
    output logic        port0_dirty_o,

    // Port 1, read only, brought out as the probe port
    input  wire logic   port1_rd_en_i,
    input  wire index_t port1_index_i,
    output logic        port1_valid_o,
    output logic        port1_dirty_o
);

    // ------------------------------
    // Status banks
    // ------------------------------

    // Valid and dirty live in separate banks
    // Both banks share the port 0 write enable since every update sets both bits
    logic valid_bank [0:`CACHE_DEPTH-1];
    logic dirty_bank [0:`CACHE_DEPTH-1];

    // Port 0 owns the write side of both banks
    // Reset empties the whole directory, so no line can hit after reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `CACHE_DEPTH; i++) begin
                valid_bank[i] <= 1'b0;
                dirty_bank[i] <= 1'b0;
            end
            port0_valid_o <= 1'b0;
            port0_dirty_o <= 1'b0;
        end else begin
            if (port0_wr_en_i) begin
                valid_bank[port0_index_i] <= port0_valid_i;
                dirty_bank[port0_index_i] <= port0_dirty_i;
            end
            // Read register holds its value between reads
            if (port0_rd_en_i) begin
                port0_valid_o <= valid_bank[port0_index_i];
                port0_dirty_o <= dirty_bank[port0_index_i];
            end
        end
    end

    // ------------------------------
    // Probe read port
    // ------------------------------

    // Same-edge read of an index under write sees the old bits
    // The write lands at this edge too, so the next probe sees the new ones
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            port1_valid_o <= 1'b0;
            port1_dirty_o <= 1'b0;
        end else if (port1_rd_en_i) begin
            port1_valid_o <= valid_bank[port1_index_i];
            port1_dirty_o <= dirty_bank[port1_index_i];
        end
    end

endmodule : status_memory

`default_nettype wire

// File: tag_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module tag_memory import cache_addr_pkg::*; (
    input  wire logic   clk_i,

    // Single shared port, read and write use the same index
    input  wire logic   rd_en_i,
    input  wire logic   wr_en_i,
    input  wire index_t index_i,
    input  wire tag_t   wr_tag_i,
    output tag_t        rd_tag_o
);

    // ------------------------------
    // Tag storage
    // ------------------------------

    // One tag per line
    // Contents are meaningless until the matching valid bit is set
    tag_t tag_array [0:`CACHE_DEPTH-1];

    // Write port
    // The controller only writes in its resolve cycle, after the read is done
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_array[index_i] <= wr_tag_i;
        end
    end

    // ------------------------------
    // Registered read
    // ------------------------------

    // Read data appears the cycle after rd_en_i and then holds
    // Holding lets the controller use it for the whole resolve cycle
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_tag_o <= tag_array[index_i];
        end
    end

    // A read and a write at the same edge return the old tag
    // The controller never issues both together, so this is not relied on

endmodule : tag_memory

`default_nettype wire

// File: tb_cache_directory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_defines.svh"

module tb_cache_directory import cache_addr_pkg::*, cache_op_pkg::*; ();

    // Probes count as steps, ten cycles cover the longest held transaction
    localparam int DIRECTED_STEPS = 40;
    localparam int RANDOM_STEPS   = 200;
    localparam int CYCLE_LIMIT    = (DIRECTED_STEPS + RANDOM_STEPS) * 10 + 100;

    logic      clk;
    logic      reset;
    logic      req;
    cache_op_t op;
    addr_t     addr;
    logic      ack;
    logic      hit;
    logic      dirty;
    logic      writeback;
    tag_t      victim_tag;
    logic      probe_en;
    index_t    probe_index;
    logic      probe_valid;
    logic      probe_dirty;

    // Reference directory, updated after each completed handshake
    tag_t ref_tag   [0:`CACHE_DEPTH-1];
    logic ref_valid [0:`CACHE_DEPTH-1];
    logic ref_dirty [0:`CACHE_DEPTH-1];
    // Only three tags in the random phase, so hits and evictions are common
    tag_t tag_pool  [0:2];

    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int seed   = 38011;

    cache_directory_top u_dut (
        .clk_i (clk), .reset_i (reset),
        .req_i (req), .op_i (op), .addr_i (addr), .ack_o (ack),
        .hit_o (hit), .dirty_o (dirty), .writeback_o (writeback), .victim_tag_o (victim_tag),
        .probe_en_i (probe_en), .probe_index_i (probe_index),
        .probe_valid_o (probe_valid), .probe_dirty_o (probe_dirty)
    );

    always #20 clk = ~clk;

    // ------------------------------
    // Helpers
    // ------------------------------

    function automatic addr_t line_addr(input tag_t t, input index_t i,
                                        input logic [`OFFSET_WIDTH-1:0] off);
        return {t, i, off};
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic print_counts();
        $display("Checks: %0d, errors: %0d, bound assertion failures: %0d",
                 checks, errors, u_dut.u_chk.failures);
    endtask

    // One four-phase handshake, req_i held for hold extra cycles after ack_o
    task automatic run_op(input cache_op_t t_op, input addr_t t_addr, input int hold);
        index_t idx;
        tag_t   tg;
        logic   exp_hit;
        logic   exp_wb;
        tag_t   exp_victim;
        int     waited;
        idx = t_addr[`OFFSET_WIDTH +: `INDEX_WIDTH];
        tg  = t_addr[`ADDR_WIDTH-1 -: `TAG_WIDTH];
        // Expected response comes from the model before it is updated
        exp_hit    = ref_valid[idx] && (ref_tag[idx] == tg);
        exp_wb     = (t_op == OP_INVALIDATE) && exp_hit && ref_dirty[idx];
        exp_victim = '0;
        if (t_op == OP_FILL) begin
            exp_wb     = ref_valid[idx] && ref_dirty[idx];
            exp_victim = ref_valid[idx] ? ref_tag[idx] : '0;
        end
        @(negedge clk);
        op     = t_op;
        addr   = t_addr;
        req    = 1'b1;
        waited = 0;
        while (!ack && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (!ack) begin
            errors++;
            $display("ack_o did not rise within %0d cycles of req_i", waited);
        end else begin
            // Sampling edge plus three cycles puts ack_o at the fourth falling edge
            check_value("ack_o latency", 32'(3), 32'(waited - 1));
        end
        for (int i = 0; i <= hold; i++) begin
            if (i > 0) @(negedge clk);
            check_value("ack_o", 32'(1), 32'(ack));
            check_value("hit_o", 32'(exp_hit), 32'(hit));
            check_value("dirty_o", 32'(exp_hit && ref_dirty[idx]), 32'(dirty));
            check_value("writeback_o", 32'(exp_wb), 32'(writeback));
            check_value("victim_tag_o", 32'(exp_victim), 32'(victim_tag));
        end
        req    = 1'b0;
        waited = 0;
        while (ack && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (ack) begin
            errors++;
            $display("ack_o stayed high after req_i was dropped");
        end
        case (t_op)
            OP_FILL: begin
                ref_tag[idx]   = tg;
                ref_valid[idx] = 1'b1;
                ref_dirty[idx] = 1'b0;
            end
            OP_WRITE: if (exp_hit) ref_dirty[idx] = 1'b1;
            OP_INVALIDATE: if (exp_hit) begin
                ref_valid[idx] = 1'b0;
                ref_dirty[idx] = 1'b0;
            end
            default: ;
        endcase
    endtask

    // Probe bits are registered at the rising edge between the two falling edges
    task automatic probe_line(input index_t idx);
        @(negedge clk);
        probe_en    = 1'b1;
        probe_index = idx;
        @(negedge clk);
        probe_en = 1'b0;
        check_value("probe_valid_o", 32'(ref_valid[idx]), 32'(probe_valid));
        check_value("probe_dirty_o", 32'(ref_dirty[idx]), 32'(probe_dirty));
    endtask

    // ------------------------------
    // Timeout
    // ------------------------------

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            print_counts();
            $display("Result: FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------

    initial begin
        int r;
        int pick;
        clk         = 1'b0;
        reset       = 1'b1;
        req         = 1'b0;
        op          = OP_LOOKUP;
        addr        = '0;
        probe_en    = 1'b0;
        probe_index = '0;
        tag_pool[0] = 10'h155;
        tag_pool[1] = 10'h0aa;
        tag_pool[2] = 10'h3c3;
        for (int i = 0; i < `CACHE_DEPTH; i++) begin
            ref_tag[i]   = '0;
            ref_valid[i] = 1'b0;
            ref_dirty[i] = 1'b0;
        end
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // Empty directory after reset
        for (int i = 0; i < `CACHE_DEPTH; i++) probe_line(index_t'(i));
        run_op(OP_LOOKUP, line_addr(10'h155, 4'd3, 2'd1), 0);
        // Fill, then hit with the same tag and miss with another one
        run_op(OP_FILL, line_addr(10'h155, 4'd3, 2'd0), 0);
        run_op(OP_LOOKUP, line_addr(10'h155, 4'd3, 2'd2), 0);
        run_op(OP_LOOKUP, line_addr(10'h0aa, 4'd3, 2'd0), 0);
        // Dirty the line, miss with a write, then evict the dirty line
        run_op(OP_WRITE, line_addr(10'h155, 4'd3, 2'd3), 0);
        probe_line(4'd3);
        run_op(OP_WRITE, line_addr(10'h0aa, 4'd3, 2'd0), 0);
        probe_line(4'd3);
        run_op(OP_FILL, line_addr(10'h0aa, 4'd3, 2'd0), 0);
        run_op(OP_LOOKUP, line_addr(10'h155, 4'd3, 2'd0), 0);
        // Invalidate of a dirty hit asks for a write-back and empties the line
        run_op(OP_WRITE, line_addr(10'h0aa, 4'd3, 2'd1), 0);
        run_op(OP_INVALIDATE, line_addr(10'h0aa, 4'd3, 2'd1), 0);
        probe_line(4'd3);
        // Client holds req_i well past ack_o
        run_op(OP_FILL, line_addr(10'h3c3, 4'd9, 2'd0), 6);
        run_op(OP_WRITE, line_addr(10'h3c3, 4'd9, 2'd2), 4);
        run_op(OP_LOOKUP, line_addr(10'h3c3, 4'd9, 2'd0), 5);

        // Random mix over four indexes and three tags
        for (int n = 0; n < RANDOM_STEPS; n++) begin
            r = $random(seed);
            if (((r >> 2) & 3) == 0) begin
                probe_line(r[11:8]);
            end else begin
                pick = (r >> 4) & 3;
                if (pick == 3) pick = 1;
                run_op(cache_op_t'(r[1:0]), line_addr(tag_pool[pick], {2'b10, r[9:8]}, r[13:12]),
                       (r >> 14) & 3);
            end
        end

        @(negedge clk);
        print_counts();
        if (errors == 0 && u_dut.u_chk.failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : tb_cache_directory

`default_nettype wire
